//--- hw/sike_apb_pkg.sv
// isogeny accelerator APB bridge
// address map, command codes and the types shared by the bridge blocks
package sike_apb_pkg;

  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 8;
  localparam int NUM_SLOTS = 24;
  localparam int SLOT_W    = $clog2(NUM_SLOTS);

  // ----------------------------------------------------------
  // register map
  // ----------------------------------------------------------
  localparam logic [ADDR_W-1:0] ADDR_CTRL         = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_LOOPS        = 8'h08;
  localparam logic [ADDR_W-1:0] ADDR_INDEX        = 8'h0C;
  // one window per slot, stride of one word
  localparam logic [ADDR_W-1:0] ADDR_OPERAND_BASE = 8'h10;

  // slots watched by the load-ready flags
  localparam logic [SLOT_W-1:0] SLOT_Z4_1 = SLOT_W'(23);
  localparam logic [SLOT_W-1:0] SLOT_ZP_1 = SLOT_W'(11);
  localparam logic [SLOT_W-1:0] SLOT_Z4_0 = SLOT_W'(22);

  typedef logic [7:0] cmd_t;

  localparam cmd_t CMD_XDBLE       = 8'd1;
  localparam cmd_t CMD_GET_4_ISOG  = 8'd2;
  localparam cmd_t CMD_EVAL_4_ISOG = 8'd3;
  localparam cmd_t CMD_XADD_LOOP   = 8'd4;

  // ----------------------------------------------------------
  // write data views
  // ----------------------------------------------------------
  typedef struct packed {
    logic [15:0] reserved;
    cmd_t        command;
    logic [5:0]  unused;
    logic        core_start;
    logic        core_rst;
  } ctrl_word_t;

  typedef struct packed {
    logic [15:0] end_index;
    logic [15:0] start_index;
  } index_word_t;

  // same PWDATA word, meaning picked by the address
  typedef union packed {
    ctrl_word_t  ctrl;
    index_word_t index;
  } apb_wdata_u;

  typedef enum logic [1:0] {
    RD_NONE,
    RD_STATUS_CORE,
    RD_STATUS_ISOG,
    RD_OPERAND
  } rd_sel_t;

  typedef struct packed {
    logic              en;
    logic [SLOT_W-1:0] slot;
    logic [DATA_W-1:0] data;
  } bank_wr_t;

  typedef struct packed {
    logic              en;
    logic [SLOT_W-1:0] slot;
  } bank_rd_t;

  // bridge to accelerator
  typedef struct packed {
    logic        core_rst;
    logic        core_start;
    cmd_t        command;
    logic [15:0] xdble_loops;
    logic [15:0] xadd_start_index;
    logic [15:0] xadd_end_index;
    logic        eval_xz_newly_init;
    logic        xadd_p_newly_loaded;
    logic        eval_result_can_overwrite;
  } core_ctrl_t;

  // accelerator to bridge, all levels
  typedef struct packed {
    logic xdbl_xadd_busy;
    logic get_4_isog_busy;
    logic eval_xz_can_overwrite;
    logic eval_result_ready;
    logic xadd_p_can_overwrite;
  } core_status_t;

endpackage

//--- hw/apb_reg_decode.sv
// APB register decode
// configuration registers, core pulses and operand write/read strobes
`timescale 1ns/1ps

module apb_reg_decode (
  input  logic                                 io_mainClk,
  input  logic                                 io_systemReset,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [sike_apb_pkg::ADDR_W-1:0]      paddr,
  input  logic [sike_apb_pkg::DATA_W-1:0]      pwdata,
  output sike_apb_pkg::bank_wr_t               bank_wr,
  output sike_apb_pkg::bank_rd_t               bank_rd,
  output sike_apb_pkg::rd_sel_t                rd_sel,
  output logic                                 core_rst,
  output logic                                 core_start,
  output sike_apb_pkg::cmd_t                   command,
  output logic [15:0]                          xdble_loops,
  output logic [15:0]                          xadd_start_index,
  output logic [15:0]                          xadd_end_index
);

  import sike_apb_pkg::*;

  logic              do_write;
  logic              do_read;
  logic [ADDR_W-1:0] offset;
  logic              operand_hit;
  logic [SLOT_W-1:0] slot;
  apb_wdata_u        wdata_u;
  logic              wr_en_q;
  logic [SLOT_W-1:0] wr_slot_q;
  logic [DATA_W-1:0] wr_data_q;

  // slave is always ready
  assign do_write = psel && penable && pwrite;
  assign do_read  = psel && penable && !pwrite;

  assign wdata_u = pwdata;

  // operand windows are word aligned above the base
  assign offset      = paddr - ADDR_OPERAND_BASE;
  assign operand_hit = (paddr >= ADDR_OPERAND_BASE) && (offset[1:0] == 2'b00) &&
                       (offset[ADDR_W-1:2] < NUM_SLOTS);
  assign slot        = offset[SLOT_W+1:2];

  // ----------------------------------------------------------
  // writes
  // ----------------------------------------------------------
  always_ff @(posedge io_mainClk or posedge io_systemReset) begin
    if (io_systemReset) begin
      core_rst         <= 1'b0;
      core_start       <= 1'b0;
      command          <= '0;
      xdble_loops      <= '0;
      xadd_start_index <= '0;
      xadd_end_index   <= '0;
      wr_en_q          <= 1'b0;
    end else begin
      core_rst   <= 1'b0;
      core_start <= 1'b0;
      wr_en_q    <= do_write && operand_hit;
      if (do_write) begin
        case (paddr)
          ADDR_CTRL: begin
            core_rst   <= wdata_u.ctrl.core_rst;
            core_start <= wdata_u.ctrl.core_start;
            command    <= wdata_u.ctrl.command;
          end
          ADDR_LOOPS: begin
            xdble_loops <= pwdata[15:0];
          end
          ADDR_INDEX: begin
            xadd_start_index <= wdata_u.index.start_index;
            xadd_end_index   <= wdata_u.index.end_index;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // operand word and slot held for the bank write
  always_ff @(posedge io_mainClk) begin
    if (do_write && operand_hit) begin
      wr_slot_q <= slot;
      wr_data_q <= pwdata;
    end
  end

  assign bank_wr = '{en: wr_en_q, slot: wr_slot_q, data: wr_data_q};

  // ----------------------------------------------------------
  // reads
  // ----------------------------------------------------------
  always_comb begin
    rd_sel = RD_NONE;
    if (do_read) begin
      if (paddr == ADDR_CTRL) begin
        rd_sel = RD_STATUS_CORE;
      end else if (paddr == ADDR_LOOPS) begin
        rd_sel = RD_STATUS_ISOG;
      end else if (operand_hit) begin
        rd_sel = RD_OPERAND;
      end
    end
  end

  assign bank_rd = '{en: do_read && operand_hit, slot: slot};

  // APB needs a setup cycle between accesses
  a_start_pulse: assert property (@(posedge io_mainClk) disable iff (io_systemReset)
    core_start |=> !core_start);
  a_rst_pulse: assert property (@(posedge io_mainClk) disable iff (io_systemReset)
    core_rst |=> !core_rst);

endmodule

//--- hw/operand_bank.sv
// operand bank
// local storage of all operand windows with shared wrapping word counters
`timescale 1ns/1ps

module operand_bank #(
  parameter int WORDS_PER_OPERAND = 4
) (
  input  logic                                io_mainClk,
  input  logic                                io_systemReset,
  input  logic                                core_rst,
  input  sike_apb_pkg::bank_wr_t              bank_wr,
  input  sike_apb_pkg::bank_rd_t              bank_rd,
  output logic [sike_apb_pkg::DATA_W-1:0]     rdata,
  output logic                                wr_last,
  output logic                                rd_last,
  output logic [sike_apb_pkg::SLOT_W-1:0]     wr_slot,
  output logic [sike_apb_pkg::SLOT_W-1:0]     rd_slot
);

  import sike_apb_pkg::*;

  localparam int PTR_W = (WORDS_PER_OPERAND > 1) ? $clog2(WORDS_PER_OPERAND) : 1;
  localparam logic [PTR_W-1:0] LAST_WORD = PTR_W'(WORDS_PER_OPERAND - 1);

  logic [DATA_W-1:0] mem [NUM_SLOTS][WORDS_PER_OPERAND];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic              wr_at_last;
  logic              rd_at_last;

  assign wr_at_last = (wr_ptr == LAST_WORD);
  assign rd_at_last = (rd_ptr == LAST_WORD);

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------
  always_ff @(posedge io_mainClk) begin
    if (bank_wr.en) begin
      mem[bank_wr.slot][wr_ptr] <= bank_wr.data;
    end
  end

  // read data is combinational in the access cycle
  assign rdata = mem[bank_rd.slot][rd_ptr];

  // ----------------------------------------------------------
  // word counters
  // ----------------------------------------------------------
  always_ff @(posedge io_mainClk or posedge io_systemReset) begin
    if (io_systemReset) begin
      wr_ptr <= '0;
    end else if (core_rst || (bank_wr.en && wr_at_last)) begin
      wr_ptr <= '0;
    end else if (bank_wr.en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // read side is not touched by core reset
  always_ff @(posedge io_mainClk or posedge io_systemReset) begin
    if (io_systemReset) begin
      rd_ptr <= '0;
    end else if (bank_rd.en) begin
      if (rd_at_last) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // last word of a slot reached
  assign wr_last = bank_wr.en && wr_at_last;
  assign rd_last = bank_rd.en && rd_at_last;
  assign wr_slot = bank_wr.slot;
  assign rd_slot = bank_rd.slot;

  a_wr_slot_range: assert property (@(posedge io_mainClk) disable iff (io_systemReset)
    bank_wr.en |-> (bank_wr.slot < NUM_SLOTS));
  a_rd_slot_range: assert property (@(posedge io_mainClk) disable iff (io_systemReset)
    bank_rd.en |-> (bank_rd.slot < NUM_SLOTS));

endmodule

//--- hw/status_readback.sv
// status readback
// load-ready handshake flags, status words and the APB read data mux
`timescale 1ns/1ps

module status_readback (
  input  logic                                io_mainClk,
  input  logic                                io_systemReset,
  input  sike_apb_pkg::rd_sel_t               rd_sel,
  input  logic [sike_apb_pkg::DATA_W-1:0]     rdata,
  input  sike_apb_pkg::cmd_t                  command,
  input  logic                                wr_last,
  input  logic                                rd_last,
  input  logic [sike_apb_pkg::SLOT_W-1:0]     wr_slot,
  input  logic [sike_apb_pkg::SLOT_W-1:0]     rd_slot,
  input  sike_apb_pkg::core_status_t          core_status,
  output logic [sike_apb_pkg::DATA_W-1:0]     prdata,
  output logic                                eval_xz_newly_init,
  output logic                                xadd_p_newly_loaded,
  output logic                                eval_result_can_overwrite
);

  import sike_apb_pkg::*;

  logic              eval_xz_set;
  logic              xadd_p_set;
  logic              result_set;
  logic [DATA_W-1:0] status_core;
  logic [DATA_W-1:0] status_isog;

  // second halves complete a load
  assign eval_xz_set = wr_last && (wr_slot == SLOT_Z4_1) && (command == CMD_EVAL_4_ISOG);
  assign xadd_p_set  = wr_last && (wr_slot == SLOT_ZP_1) && (command == CMD_XADD_LOOP);
  assign result_set  = rd_last && (rd_slot == SLOT_Z4_1);

  // ----------------------------------------------------------
  // handshake flags, set has priority
  // ----------------------------------------------------------
  always_ff @(posedge io_mainClk or posedge io_systemReset) begin
    if (io_systemReset) begin
      eval_xz_newly_init        <= 1'b0;
      xadd_p_newly_loaded       <= 1'b0;
      eval_result_can_overwrite <= 1'b1;
    end else begin
      if (eval_xz_set) begin
        eval_xz_newly_init <= 1'b1;
      end else if (core_status.eval_xz_can_overwrite) begin
        eval_xz_newly_init <= 1'b0;
      end

      if (xadd_p_set) begin
        xadd_p_newly_loaded <= 1'b1;
      end else if (core_status.xadd_p_can_overwrite) begin
        xadd_p_newly_loaded <= 1'b0;
      end

      // host has drained the result
      if (result_set) begin
        eval_result_can_overwrite <= 1'b1;
      end else if (core_status.eval_result_ready) begin
        eval_result_can_overwrite <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // status words and read mux
  // ----------------------------------------------------------
  always_comb begin
    status_core     = '0;
    status_core[8]  = core_status.xadd_p_can_overwrite;
    status_core[0]  = core_status.xdbl_xadd_busy;
    status_isog     = '0;
    status_isog[16] = core_status.eval_result_ready;
    status_isog[8]  = core_status.eval_xz_can_overwrite;
    status_isog[0]  = core_status.get_4_isog_busy;
  end

  always_comb begin
    case (rd_sel)
      RD_STATUS_CORE: prdata = status_core;
      RD_STATUS_ISOG: prdata = status_isog;
      RD_OPERAND:     prdata = rdata;
      default:        prdata = '0;
    endcase
  end

  // a ready result is only kept by a final Z4_1 read
  a_result_clear: assert property (@(posedge io_mainClk) disable iff (io_systemReset)
    (core_status.eval_result_ready && !(rd_last && rd_slot == SLOT_Z4_1))
      |=> !eval_result_can_overwrite);

endmodule

//--- hw/sike_apb_bridge.sv
// isogeny accelerator APB3 bridge
// joins register decode, operand bank and status readback
`timescale 1ns/1ps

module sike_apb_bridge #(
  parameter int WORDS_PER_OPERAND = 4
) (
  input  logic                                io_mainClk,
  input  logic                                io_systemReset,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [sike_apb_pkg::ADDR_W-1:0]     paddr,
  input  logic [sike_apb_pkg::DATA_W-1:0]     pwdata,
  output logic [sike_apb_pkg::DATA_W-1:0]     prdata,
  output logic                                pready,
  output logic                                pslverr,
  output sike_apb_pkg::core_ctrl_t            core_ctrl,
  input  sike_apb_pkg::core_status_t          core_status
);

  import sike_apb_pkg::*;

  bank_wr_t          bank_wr;
  bank_rd_t          bank_rd;
  rd_sel_t           rd_sel;
  logic              core_rst;
  logic              core_start;
  cmd_t              command;
  logic [15:0]       xdble_loops;
  logic [15:0]       xadd_start_index;
  logic [15:0]       xadd_end_index;
  logic [DATA_W-1:0] rdata;
  logic              wr_last;
  logic              rd_last;
  logic [SLOT_W-1:0] wr_slot;
  logic [SLOT_W-1:0] rd_slot;
  logic              eval_xz_newly_init;
  logic              xadd_p_newly_loaded;
  logic              eval_result_can_overwrite;

  // no wait states and no error response
  assign pready  = 1'b1;
  assign pslverr = 1'b0;

  apb_reg_decode i_apb_reg_decode (
    .io_mainClk       (io_mainClk),
    .io_systemReset   (io_systemReset),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .bank_wr          (bank_wr),
    .bank_rd          (bank_rd),
    .rd_sel           (rd_sel),
    .core_rst         (core_rst),
    .core_start       (core_start),
    .command          (command),
    .xdble_loops      (xdble_loops),
    .xadd_start_index (xadd_start_index),
    .xadd_end_index   (xadd_end_index)
  );

  operand_bank #(
    .WORDS_PER_OPERAND (WORDS_PER_OPERAND)
  ) i_operand_bank (
    .io_mainClk     (io_mainClk),
    .io_systemReset (io_systemReset),
    .core_rst       (core_rst),
    .bank_wr        (bank_wr),
    .bank_rd        (bank_rd),
    .rdata          (rdata),
    .wr_last        (wr_last),
    .rd_last        (rd_last),
    .wr_slot        (wr_slot),
    .rd_slot        (rd_slot)
  );

  status_readback i_status_readback (
    .io_mainClk                (io_mainClk),
    .io_systemReset            (io_systemReset),
    .rd_sel                    (rd_sel),
    .rdata                     (rdata),
    .command                   (command),
    .wr_last                   (wr_last),
    .rd_last                   (rd_last),
    .wr_slot                   (wr_slot),
    .rd_slot                   (rd_slot),
    .core_status               (core_status),
    .prdata                    (prdata),
    .eval_xz_newly_init        (eval_xz_newly_init),
    .xadd_p_newly_loaded       (xadd_p_newly_loaded),
    .eval_result_can_overwrite (eval_result_can_overwrite)
  );

  // accelerator control bundle
  assign core_ctrl = '{
    core_rst:                  core_rst,
    core_start:                core_start,
    command:                   command,
    xdble_loops:               xdble_loops,
    xadd_start_index:          xadd_start_index,
    xadd_end_index:            xadd_end_index,
    eval_xz_newly_init:        eval_xz_newly_init,
    xadd_p_newly_loaded:       xadd_p_newly_loaded,
    eval_result_can_overwrite: eval_result_can_overwrite
  };

endmodule

//--- dv/tb_sike_apb_bridge.sv
// testbench for the isogeny accelerator APB3 bridge
// directed tests over APB with a cycle limit
`timescale 1ns/1ps

module tb_sike_apb_bridge;

  import sike_apb_pkg::*;

  // 3 cycles per APB access, roughly 90 accesses over all tests
  localparam int RESET_CYCLES  = 4;
  localparam int TEST_ACCESSES = 100;
  localparam int MAX_CYCLES    = 2 * (RESET_CYCLES + 3 * TEST_ACCESSES);

  logic         io_mainClk;
  logic         io_systemReset;
  logic         psel;
  logic         penable;
  logic         pwrite;
  logic [7:0]   paddr;
  logic [31:0]  pwdata;
  logic [31:0]  prdata;
  logic         pready;
  logic         pslverr;
  core_ctrl_t   core_ctrl;
  core_status_t core_status;

  logic [31:0]  lfsr_state;
  int           error_count;
  int           check_count;
  int           cycle_count;

  sike_apb_bridge #(
    .WORDS_PER_OPERAND (4)
  ) i_sike_apb_bridge (
    .io_mainClk     (io_mainClk),
    .io_systemReset (io_systemReset),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .core_ctrl      (core_ctrl),
    .core_status    (core_status)
  );

  always #5 io_mainClk = ~io_mainClk;

  always @(posedge io_mainClk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  // galois form, x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'hD000_0001;
    end
    return state >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return value;
  endfunction

  function automatic logic [7:0] operand_addr(input int slot);
    return 8'(8'h10 + 4 * slot);
  endfunction

  function automatic logic [31:0] ctrl_word(input logic [7:0] cmd, input logic start,
                                            input logic rst);
    return {16'h0000, cmd, 6'b000000, start, rst};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("FAILED %s: got %08h expected %08h", name, got, expected);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("test %-24s ok", name);
    end else begin
      $display("test %-24s %0d mismatches", name, error_count - errors_before);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge io_mainClk);
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge io_mainClk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge io_mainClk);
    penable = 1'b1;
    @(negedge io_mainClk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // data is taken in the middle of the access cycle
  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge io_mainClk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge io_mainClk);
    penable = 1'b1;
    #2;
    data = prdata;
    @(negedge io_mainClk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic load_slot(input int slot);
    for (int w = 0; w < 4; w++) begin
      apb_write(operand_addr(slot), rand_bits(32));
    end
  endtask

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------
  task automatic test_reset_state();
    int          errors_before;
    logic [31:0] got;
    errors_before = error_count;
    check_value("core_start", core_ctrl.core_start, 0);
    check_value("core_rst", core_ctrl.core_rst, 0);
    check_value("command", core_ctrl.command, 0);
    check_value("eval_xz_newly_init", core_ctrl.eval_xz_newly_init, 0);
    check_value("xadd_p_newly_loaded", core_ctrl.xadd_p_newly_loaded, 0);
    check_value("eval_result_can_overwrite", core_ctrl.eval_result_can_overwrite, 1);
    check_value("pready", pready, 1);
    check_value("pslverr", pslverr, 0);
    apb_read(8'h04, got);
    check_value("prdata@04", got, 0);
    apb_read(8'h08, got);
    check_value("prdata@08", got, 0);
    report_test("reset_state", errors_before);
  endtask

  task automatic test_config_regs();
    int          errors_before;
    logic [31:0] data;
    errors_before = error_count;
    apb_write(8'h04, ctrl_word(8'd1, 1'b1, 1'b0));
    check_value("core_start", core_ctrl.core_start, 1);
    check_value("core_rst", core_ctrl.core_rst, 0);
    check_value("command", core_ctrl.command, 8'd1);
    idle(1);
    check_value("core_start", core_ctrl.core_start, 0);
    apb_write(8'h04, ctrl_word(8'd2, 1'b0, 1'b1));
    check_value("core_rst", core_ctrl.core_rst, 1);
    check_value("core_start", core_ctrl.core_start, 0);
    idle(1);
    check_value("core_rst", core_ctrl.core_rst, 0);
    check_value("command", core_ctrl.command, 8'd2);
    data = rand_bits(32);
    apb_write(8'h08, data);
    check_value("xdble_loops", core_ctrl.xdble_loops, data[15:0]);
    data = rand_bits(32);
    apb_write(8'h0C, data);
    check_value("xadd_start_index", core_ctrl.xadd_start_index, data[15:0]);
    check_value("xadd_end_index", core_ctrl.xadd_end_index, data[31:16]);
    report_test("config_regs", errors_before);
  endtask

  task automatic test_operand_round_trip();
    int          errors_before;
    int          slot_list [3];
    logic [31:0] words [3][4];
    logic [31:0] expect_wrap [4];
    logic [31:0] got;
    errors_before = error_count;
    slot_list = '{0, 9, 17};
    for (int s = 0; s < 3; s++) begin
      for (int w = 0; w < 4; w++) begin
        words[s][w] = rand_bits(32);
        apb_write(operand_addr(slot_list[s]), words[s][w]);
      end
    end
    for (int s = 0; s < 3; s++) begin
      for (int w = 0; w < 4; w++) begin
        apb_read(operand_addr(slot_list[s]), got);
        check_value($sformatf("slot%0d word%0d", slot_list[s], w), got, words[s][w]);
      end
    end
    // fifth word lands on word 0
    for (int w = 0; w < 4; w++) begin
      expect_wrap[w] = rand_bits(32);
      apb_write(operand_addr(2), expect_wrap[w]);
    end
    expect_wrap[0] = rand_bits(32);
    apb_write(operand_addr(2), expect_wrap[0]);
    for (int w = 0; w < 4; w++) begin
      apb_read(operand_addr(2), got);
      check_value($sformatf("slot2 word%0d", w), got, expect_wrap[w]);
    end
    // core reset mid slot restarts at word 0
    apb_write(8'h04, ctrl_word(8'd0, 1'b0, 1'b1));
    apb_write(operand_addr(3), rand_bits(32));
    apb_write(operand_addr(3), rand_bits(32));
    apb_write(8'h04, ctrl_word(8'd0, 1'b0, 1'b1));
    for (int w = 0; w < 4; w++) begin
      expect_wrap[w] = rand_bits(32);
      apb_write(operand_addr(3), expect_wrap[w]);
    end
    for (int w = 0; w < 4; w++) begin
      apb_read(operand_addr(3), got);
      check_value($sformatf("slot3 word%0d", w), got, expect_wrap[w]);
    end
    report_test("operand_round_trip", errors_before);
  endtask

  task automatic test_status_words();
    int          errors_before;
    logic [4:0]  bits;
    logic [31:0] got;
    errors_before = error_count;
    for (int p = 0; p < 4; p++) begin
      bits = (p == 3) ? 5'b11111 : 5'(rand_bits(5));
      @(negedge io_mainClk);
      core_status.xdbl_xadd_busy        = bits[0];
      core_status.get_4_isog_busy       = bits[1];
      core_status.eval_xz_can_overwrite = bits[2];
      core_status.eval_result_ready     = bits[3];
      core_status.xadd_p_can_overwrite  = bits[4];
      apb_read(8'h04, got);
      check_value("status@04", got, (32'(bits[4]) << 8) | 32'(bits[0]));
      apb_read(8'h08, got);
      check_value("status@08", got,
                  (32'(bits[3]) << 16) | (32'(bits[2]) << 8) | 32'(bits[1]));
    end
    @(negedge io_mainClk);
    core_status = '0;
    report_test("status_words", errors_before);
  endtask

  task automatic test_load_flags();
    int errors_before;
    errors_before = error_count;
    apb_write(8'h04, ctrl_word(8'd3, 1'b0, 1'b0));
    load_slot(23);
    idle(1);
    check_value("eval_xz_newly_init", core_ctrl.eval_xz_newly_init, 1);
    core_status.eval_xz_can_overwrite = 1'b1;
    idle(1);
    check_value("eval_xz_newly_init", core_ctrl.eval_xz_newly_init, 0);
    core_status.eval_xz_can_overwrite = 1'b0;
    apb_write(8'h04, ctrl_word(8'd4, 1'b0, 1'b0));
    load_slot(11);
    idle(1);
    check_value("xadd_p_newly_loaded", core_ctrl.xadd_p_newly_loaded, 1);
    check_value("eval_xz_newly_init", core_ctrl.eval_xz_newly_init, 0);
    core_status.xadd_p_can_overwrite = 1'b1;
    idle(1);
    check_value("xadd_p_newly_loaded", core_ctrl.xadd_p_newly_loaded, 0);
    core_status.xadd_p_can_overwrite = 1'b0;
    // no flag outside the matching command
    apb_write(8'h04, ctrl_word(8'd1, 1'b0, 1'b0));
    load_slot(23);
    load_slot(11);
    idle(1);
    check_value("eval_xz_newly_init", core_ctrl.eval_xz_newly_init, 0);
    check_value("xadd_p_newly_loaded", core_ctrl.xadd_p_newly_loaded, 0);
    report_test("load_flags", errors_before);
  endtask

  task automatic test_result_flag();
    int          errors_before;
    logic [31:0] got;
    errors_before = error_count;
    for (int w = 0; w < 4; w++) begin
      apb_read(operand_addr(23), got);
    end
    check_value("eval_result_can_overwrite", core_ctrl.eval_result_can_overwrite, 1);
    core_status.eval_result_ready = 1'b1;
    idle(1);
    check_value("eval_result_can_overwrite", core_ctrl.eval_result_can_overwrite, 0);
    core_status.eval_result_ready = 1'b0;
    for (int w = 0; w < 3; w++) begin
      apb_read(operand_addr(23), got);
    end
    check_value("eval_result_can_overwrite", core_ctrl.eval_result_can_overwrite, 0);
    apb_read(operand_addr(23), got);
    check_value("eval_result_can_overwrite", core_ctrl.eval_result_can_overwrite, 1);
    report_test("result_flag", errors_before);
  endtask

  // ----------------------------------------------------------
  // sequence
  // ----------------------------------------------------------
  initial begin
    io_mainClk     = 1'b0;
    io_systemReset = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    core_status    = '0;
    lfsr_state     = 32'h7c2c;
    error_count    = 0;
    check_count    = 0;
    cycle_count    = 0;
    repeat (RESET_CYCLES) @(posedge io_mainClk);
    @(negedge io_mainClk);
    io_systemReset = 1'b0;

    test_reset_state();
    test_config_regs();
    test_operand_round_trip();
    test_status_words();
    test_load_flags();
    test_result_flag();

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- vlog.f
hw/sike_apb_pkg.sv
hw/apb_reg_decode.sv
hw/operand_bank.sv
hw/status_readback.sv
hw/sike_apb_bridge.sv
dv/tb_sike_apb_bridge.sv

//--- run_sim.sh
#!/bin/sh
# build and run the APB bridge testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_sike_apb_bridge -Mdir obj_dir || { echo "build failed"; exit 1; }
./obj_dir/Vtb_sike_apb_bridge | tee sim.log
grep -q "Test failures found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log && exit 0 || { echo "no result in log"; exit 1; }
